/* common/dec_exe_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface dec_exe_if;
  import exu_pkg::*;

  logic     valid;
  word_t    pc;
  word_t    imm;
  word_t    src1;
  word_t    src2;
  reg_idx_t rd;
  logic     we;
  alu_op_e  alu_op;
  op1_sel_e op1_sel;
  op2_sel_e op2_sel;
  npc_sel_e npc_sel;
  wb_sel_e  wb_sel;

  modport decode (
    output valid, pc, imm, src1, src2, rd, we,
    output alu_op, op1_sel, op2_sel, npc_sel, wb_sel
  );

  modport execute (
    input valid, pc, imm, src1, src2, rd, we,
    input alu_op, op1_sel, op2_sel, npc_sel, wb_sel
  );

endinterface

`default_nettype wire

/* common/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Data path width in bits
`define EXU_XLEN 32

// Architectural register count
`define EXU_NREGS 32

// Sequential pc increment
`define EXU_PC_STEP 4

`endif

/* common/exu_pkg.sv */
`default_nettype none

`include "exu_config.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // Compare codes leave 0 or 1 in bit 0
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // FWD is the previous execute result
  typedef enum logic [1:0] {OP1_REG, OP1_FWD, OP1_ZERO} op1_sel_e;
  typedef enum logic [1:0] {OP2_REG, OP2_IMM, OP2_FWD} op2_sel_e;

  typedef enum logic [1:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH} npc_sel_e;

  // LINK is pc plus 4 and TARGET is pc plus imm
  typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_TARGET} wb_sel_e;

endpackage

`default_nettype wire

/* dv/exu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_tb;

  localparam int NUM_INSTS   = 400;
  localparam int CLK_PERIOD  = 8;
  localparam int WATCHDOG_NS = NUM_INSTS * 40 * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'h5b601794;

  typedef struct packed {
    logic [31:0] pc;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        taken;
    logic [31:0] npc;
  } expect_t;

  logic        clock = 1'b0;
  logic        reset;
  logic        block;
  logic        in_valid;
  logic [31:0] in_pc;
  logic [31:0] in_inst;
  logic        result_valid;
  logic [31:0] result_pc;
  logic [4:0]  result_rd;
  logic        result_we;
  logic [31:0] result_data;
  logic        redirect;
  logic [31:0] redirect_pc;

  logic [31:0] fetch_rng;
  logic [31:0] block_rng;
  logic [31:0] model_regs [32];
  expect_t     exp_q [$];

  exu_top exu_top_inst (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .in_valid     (in_valid),
    .in_pc        (in_pc),
    .in_inst      (in_inst),
    .result_valid (result_valid),
    .result_pc    (result_pc),
    .result_rd    (result_rd),
    .result_we    (result_we),
    .result_data  (result_data),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fetch_rand();
    fetch_rng = xorshift32(fetch_rng);
    return fetch_rng;
  endfunction

  function automatic logic [31:0] block_rand();
    block_rng = xorshift32(block_rng);
    return block_rng;
  endfunction

  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic fail_with(input string why);
    $display("ERROR at %0t: %s", $time, why);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Random legal instruction with registers limited to x0..x7 for dense dependencies
  function automatic logic [31:0] make_inst();
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [12:0] b13;
    logic [20:0] j21;
    logic [31:0] off32;
    logic [31:0] base;
    r     = fetch_rand();
    s     = fetch_rand();
    kind  = r[4:0];
    rd    = {2'b00, s[2:0]};
    rs1   = {2'b00, s[5:3]};
    rs2   = {2'b00, s[8:6]};
    f3    = s[11:9];
    imm12 = s[31:20];
    if (kind < 5'd9) begin
      return {((f3 == 3'd0 || f3 == 3'd5) && r[5]) ? 7'h20 : 7'h00,
              rs2, rs1, f3, rd, 7'h33};
    end else if (kind < 5'd18) begin
      if (f3 == 3'd1) begin
        imm12 = {7'h00, s[24:20]};
      end else if (f3 == 3'd5) begin
        imm12 = {r[5] ? 7'h20 : 7'h00, s[24:20]};
      end
      return {imm12, rs1, f3, rd, 7'h13};
    end else if (kind < 5'd21) begin
      return {r[31:12], rd, 7'h37};
    end else if (kind < 5'd23) begin
      return {r[31:12], rd, 7'h17};
    end else if (kind < 5'd27) begin
      if (f3 == 3'd2 || f3 == 3'd3) begin
        f3 = f3 + 3'd2;
      end
      b13 = {{6{r[10]}}, r[10:6], 2'b00};
      return {b13[12], b13[10:5], rs2, rs1, f3, b13[4:1], b13[11], 7'h63};
    end else if (kind < 5'd29) begin
      j21 = {{12{r[12]}}, r[12:6], 2'b00};
      return {j21[20], j21[10:1], j21[11], j21[19:12], rd, 7'h6f};
    end
    // jalr offset lands on a word boundary and sometimes sets bit 0
    base  = model_regs[rs1];
    off32 = {{22{r[13]}}, r[13:6], 2'b00};
    off32 = off32 - {30'b0, base[1:0]} + {31'b0, r[5]};
    return {off32[11:0], rs1, 3'b000, rd, 7'h67};
  endfunction

  function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Architectural result of one instruction on the model registers
  function automatic expect_t run_reference(input logic [31:0] inst, input logic [31:0] pc);
    expect_t     e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i_imm;
    logic [31:0] b_imm;
    logic [31:0] u_imm;
    logic [31:0] j_imm;
    logic [2:0]  f3;
    logic        cond;
    f3    = inst[14:12];
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    i_imm = {{20{inst[31]}}, inst[31:20]};
    b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    u_imm = {inst[31:12], 12'b0};
    j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    e     = '0;
    e.pc  = pc;
    e.rd  = inst[11:7];
    e.npc = pc + 32'd4;
    case (inst[6:0])
      7'h37: begin
        e.we   = 1'b1;
        e.data = u_imm;
      end
      7'h17: begin
        e.we   = 1'b1;
        e.data = pc + u_imm;
      end
      7'h6f: begin
        e.we    = 1'b1;
        e.data  = pc + 32'd4;
        e.taken = 1'b1;
        e.npc   = pc + j_imm;
      end
      7'h67: begin
        e.we    = 1'b1;
        e.data  = pc + 32'd4;
        e.taken = 1'b1;
        e.npc   = (a + i_imm) & 32'hffff_fffe;
      end
      7'h63: begin
        case (f3)
          3'd0:    cond = a == b;
          3'd1:    cond = a != b;
          3'd4:    cond = $signed(a) < $signed(b);
          3'd5:    cond = $signed(a) >= $signed(b);
          3'd6:    cond = a < b;
          default: cond = a >= b;
        endcase
        e.taken = cond;
        if (cond) begin
          e.npc = pc + b_imm;
        end
      end
      7'h13: begin
        e.we   = 1'b1;
        e.data = alu_calc(f3, inst[30] && f3 == 3'd5, a, i_imm);
      end
      default: begin
        e.we   = 1'b1;
        e.data = alu_calc(f3, inst[30], a, b);
      end
    endcase
    return e;
  endfunction

  // Holds the instruction until an edge accepts it
  task automatic send_inst(input logic [31:0] pc, input logic [31:0] inst);
    logic accepted;
    in_valid = 1'b1;
    in_pc    = pc;
    in_inst  = inst;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clock);
      accepted = !block && !redirect;
      @(posedge clock);
      #1;
    end
  endtask

  initial begin
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] r;
    expect_t     want;
    reset     = 1'b1;
    block     = 1'b0;
    in_valid  = 1'b0;
    in_pc     = '0;
    in_inst   = '0;
    fetch_rng = SEED;
    block_rng = SEED ^ 32'h9e3779b9;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    pc = 32'h0000_1000;
    for (int n = 0; n < NUM_INSTS; n++) begin
      r = fetch_rand();
      if (r[2:0] == 3'd0) begin
        in_valid = 1'b0;
        @(posedge clock);
        #1;
      end
      inst = make_inst();
      want = run_reference(inst, pc);
      exp_q.push_back(want);
      if (want.we && want.rd != 5'd0) begin
        model_regs[want.rd] = want.data;
      end
      send_inst(pc, inst);
      // Wrong-path instruction right behind a taken transfer gets squashed
      if (want.taken) begin
        send_inst(pc + 32'd4, make_inst());
      end
      pc = want.npc;
    end
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clock);
    end
    repeat (10) @(posedge clock);
    $display("Everything OK");
    $finish;
  end

  initial begin
    logic [31:0] r;
    int          hold;
    hold = 0;
    repeat (4) @(posedge clock);
    forever begin
      #1;
      r = block_rand();
      if (hold > 0) begin
        block = 1'b1;
        hold  = hold - 1;
      end else if (r[2:0] == 3'd0) begin
        block = 1'b1;
        hold  = int'(r[5:4]);
      end else begin
        block = 1'b0;
      end
      @(posedge clock);
    end
  end

  // A beat retires on the next edge with block low
  always @(negedge clock) begin
    expect_t want;
    if (!reset) begin
      if (!result_valid) begin
        assert (!redirect) else fail_with("redirect raised without a valid result");
      end else if (!block) begin
        assert (exp_q.size() > 0) else fail_with("result seen with no pending instruction");
        want = exp_q.pop_front();
        check_value("result_pc", result_pc, want.pc);
        check_value("result_we", 32'(result_we), 32'(want.we));
        if (want.we) begin
          check_value("result_rd", 32'(result_rd), 32'(want.rd));
          check_value("result_data", result_data, want.data);
        end
        check_value("redirect", 32'(redirect), 32'(want.taken));
        if (want.taken) begin
          check_value("redirect_pc", redirect_pc, want.npc);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_with("watchdog expired before all results were seen");
  end

endmodule

`default_nettype wire

/* execute/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  exu_pkg::alu_op_e op,
  input  exu_pkg::word_t   a,
  input  exu_pkg::word_t   b,
  output exu_pkg::word_t   result
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = a == b;

  always_comb begin
    result = '0;
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_SLT:  result = word_t'(lt_s);
      ALU_SLTU: result = word_t'(lt_u);
      // Branch compares
      ALU_EQ:   result = word_t'(eq);
      ALU_NE:   result = word_t'(!eq);
      ALU_LT:   result = word_t'(lt_s);
      ALU_GE:   result = word_t'(!lt_s);
      ALU_LTU:  result = word_t'(lt_u);
      ALU_GEU:  result = word_t'(!lt_u);
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* execute/exec_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_config.svh"

module exec_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              block,
  dec_exe_if.execute        dec,
  output logic              result_valid,
  output exu_pkg::word_t    result_pc,
  output exu_pkg::reg_idx_t result_rd,
  output logic              result_we,
  output exu_pkg::word_t    result_data,
  output logic              redirect,
  output exu_pkg::word_t    redirect_pc
);
  import exu_pkg::*;

  logic     valid_q;
  logic     we_q;
  npc_sel_e npc_sel_q;
  wb_sel_e  wb_sel_q;
  alu_op_e  alu_op_q;
  word_t    pc_q;
  reg_idx_t rd_q;
  word_t    operand1;
  word_t    operand2;
  word_t    snpc;
  word_t    dnpc;
  word_t    op1_d;
  word_t    op2_d;
  word_t    alu_result;
  word_t    wb_data;
  word_t    npc;
  logic     taken;

  // Forwarded operands come from the result currently on display
  always_comb begin
    case (dec.op1_sel)
      OP1_FWD:  op1_d = wb_data;
      OP1_ZERO: op1_d = '0;
      default:  op1_d = dec.src1;
    endcase
    case (dec.op2_sel)
      OP2_IMM: op2_d = dec.imm;
      OP2_FWD: op2_d = wb_data;
      default: op2_d = dec.src2;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q   <= 1'b0;
      we_q      <= 1'b0;
      npc_sel_q <= NPC_SEQ;
    end else if (!block) begin
      // Younger instruction is dropped on a taken transfer
      valid_q   <= dec.valid && !redirect;
      we_q      <= dec.we;
      npc_sel_q <= dec.npc_sel;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      alu_op_q <= dec.alu_op;
      wb_sel_q <= dec.wb_sel;
      pc_q     <= dec.pc;
      rd_q     <= dec.rd;
      operand1 <= op1_d;
      operand2 <= op2_d;
      snpc     <= dec.pc + `EXU_PC_STEP;
      dnpc     <= dec.pc + dec.imm;
    end
  end

  alu alu_inst (
    .op     (alu_op_q),
    .a      (operand1),
    .b      (operand2),
    .result (alu_result)
  );

  always_comb begin
    case (wb_sel_q)
      WB_LINK:   wb_data = snpc;
      WB_TARGET: wb_data = dnpc;
      default:   wb_data = alu_result;
    endcase
  end

  always_comb begin
    taken = 1'b0;
    npc   = snpc;
    case (npc_sel_q)
      NPC_JAL: begin
        taken = 1'b1;
        npc   = dnpc;
      end
      NPC_JALR: begin
        taken = 1'b1;
        npc   = {alu_result[`EXU_XLEN-1:1], 1'b0};
      end
      NPC_BRANCH: begin
        taken = alu_result[0];
        npc   = alu_result[0] ? dnpc : snpc;
      end
      default: ;
    endcase
  end

  assign result_valid = valid_q;
  assign result_pc    = pc_q;
  assign result_rd    = rd_q;
  assign result_we    = valid_q && we_q;
  assign result_data  = wb_data;
  assign redirect     = valid_q && taken;
  assign redirect_pc  = npc;

endmodule

`default_nettype wire

/* rtl/exu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              block,
  input  logic              in_valid,
  input  exu_pkg::word_t    in_pc,
  input  logic [31:0]       in_inst,
  output logic              result_valid,
  output exu_pkg::word_t    result_pc,
  output exu_pkg::reg_idx_t result_rd,
  output logic              result_we,
  output exu_pkg::word_t    result_data,
  output logic              redirect,
  output exu_pkg::word_t    redirect_pc
);
  import exu_pkg::*;

  reg_idx_t ra1;
  reg_idx_t ra2;
  word_t    rd1;
  word_t    rd2;

  dec_exe_if dec_exe_bus ();

  // Write lands on the edge after the result is shown
  reg_file reg_file_inst (
    .clock (clock),
    .reset (reset),
    .ra1   (ra1),
    .ra2   (ra2),
    .rd1   (rd1),
    .rd2   (rd2),
    .we    (result_we && !block),
    .wa    (result_rd),
    .wd    (result_data)
  );

  inst_decoder inst_decoder_inst (
    .clock    (clock),
    .reset    (reset),
    .block    (block),
    .in_valid (in_valid),
    .in_pc    (in_pc),
    .in_inst  (in_inst),
    .redirect (redirect),
    .ra1      (ra1),
    .ra2      (ra2),
    .rd1      (rd1),
    .rd2      (rd2),
    .dec      (dec_exe_bus.decode)
  );

  exec_stage exec_stage_inst (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .dec          (dec_exe_bus.execute),
    .result_valid (result_valid),
    .result_pc    (result_pc),
    .result_rd    (result_rd),
    .result_we    (result_we),
    .result_data  (result_data),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
  input  logic              clock,
  input  logic              reset,
  input  logic              block,
  input  logic              in_valid,
  input  exu_pkg::word_t    in_pc,
  input  logic [31:0]       in_inst,
  input  logic              redirect,
  output exu_pkg::reg_idx_t ra1,
  output exu_pkg::reg_idx_t ra2,
  input  exu_pkg::word_t    rd1,
  input  exu_pkg::word_t    rd2,
  dec_exe_if.decode         dec
);
  import exu_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   inst_rd;
  logic       accept;
  logic       fwd1;
  logic       fwd2;
  logic       use1;
  logic       use2;
  word_t      imm_d;
  logic       we_d;
  alu_op_e    alu_d;
  op1_sel_e   op1_d;
  op2_sel_e   op2_d;
  npc_sel_e   npc_d;
  wb_sel_e    wb_d;
  reg_idx_t   rs1_q;
  reg_idx_t   rs2_q;

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'b001:  return ALU_NE;
      3'b100:  return ALU_LT;
      3'b101:  return ALU_GE;
      3'b110:  return ALU_LTU;
      3'b111:  return ALU_GEU;
      default: return ALU_EQ;
    endcase
  endfunction

  assign opcode  = in_inst[6:0];
  assign funct3  = in_inst[14:12];
  assign inst_rd = in_inst[11:7];
  assign rs1     = in_inst[19:15];
  assign rs2     = in_inst[24:20];
  assign accept  = in_valid && !redirect;

  // Instruction now in decode moves to execute on the same edge
  assign fwd1 = dec.valid && dec.we && dec.rd != '0 && dec.rd == rs1;
  assign fwd2 = dec.valid && dec.we && dec.rd != '0 && dec.rd == rs2;

  always_comb begin
    imm_d = '0;
    we_d  = 1'b0;
    alu_d = ALU_ADD;
    op1_d = OP1_REG;
    op2_d = OP2_REG;
    npc_d = NPC_SEQ;
    wb_d  = WB_ALU;
    use1  = 1'b0;
    use2  = 1'b0;
    case (opcode)
      OPC_LUI: begin
        imm_d = {in_inst[31:12], 12'b0};
        we_d  = 1'b1;
        op1_d = OP1_ZERO;
        op2_d = OP2_IMM;
      end
      OPC_AUIPC: begin
        imm_d = {in_inst[31:12], 12'b0};
        we_d  = 1'b1;
        wb_d  = WB_TARGET;
      end
      OPC_JAL: begin
        imm_d = {{12{in_inst[31]}}, in_inst[19:12], in_inst[20], in_inst[30:21], 1'b0};
        we_d  = 1'b1;
        npc_d = NPC_JAL;
        wb_d  = WB_LINK;
      end
      OPC_JALR: begin
        imm_d = {{20{in_inst[31]}}, in_inst[31:20]};
        we_d  = 1'b1;
        use1  = 1'b1;
        op2_d = OP2_IMM;
        npc_d = NPC_JALR;
        wb_d  = WB_LINK;
      end
      OPC_BRANCH: begin
        imm_d = {{20{in_inst[31]}}, in_inst[7], in_inst[30:25], in_inst[11:8], 1'b0};
        use1  = 1'b1;
        use2  = 1'b1;
        alu_d = branch_op(funct3);
        npc_d = NPC_BRANCH;
      end
      OPC_OPIMM: begin
        imm_d = {{20{in_inst[31]}}, in_inst[31:20]};
        we_d  = 1'b1;
        use1  = 1'b1;
        op2_d = OP2_IMM;
        // Only srai uses the alternate bit
        alu_d = arith_op(funct3, in_inst[30] && funct3 == 3'b101);
      end
      OPC_OP: begin
        we_d  = 1'b1;
        use1  = 1'b1;
        use2  = 1'b1;
        alu_d = arith_op(funct3, in_inst[30]);
      end
      default: ;
    endcase
    if (use1 && fwd1) begin
      op1_d = OP1_FWD;
    end
    if (use2 && fwd2) begin
      op2_d = OP2_FWD;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dec.valid   <= 1'b0;
      dec.we      <= 1'b0;
      dec.npc_sel <= NPC_SEQ;
    end else if (!block) begin
      dec.valid <= accept;
      if (accept) begin
        dec.we      <= we_d;
        dec.npc_sel <= npc_d;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!block && accept) begin
      dec.pc      <= in_pc;
      dec.imm     <= imm_d;
      dec.rd      <= inst_rd;
      dec.alu_op  <= alu_d;
      dec.op1_sel <= op1_d;
      dec.op2_sel <= op2_d;
      dec.wb_sel  <= wb_d;
      rs1_q       <= rs1;
      rs2_q       <= rs2;
    end
  end

  // Registers are read while the instruction sits in decode
  assign ra1      = rs1_q;
  assign ra2      = rs2_q;
  assign dec.src1 = rd1;
  assign dec.src2 = rd2;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_config.svh"

module reg_file (
  input  logic             clock,
  input  logic             reset,
  input  exu_pkg::reg_idx_t ra1,
  input  exu_pkg::reg_idx_t ra2,
  output exu_pkg::word_t   rd1,
  output exu_pkg::word_t   rd2,
  input  logic             we,
  input  exu_pkg::reg_idx_t wa,
  input  exu_pkg::word_t   wd
);
  import exu_pkg::*;

  word_t regs [`EXU_NREGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // x0 reads as zero
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module exu_tb -f tb.f -o exu_sim
./obj_dir/exu_sim | tee sim.log
if grep -qx "Everything OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* tb.f */
+incdir+common
common/exu_pkg.sv
common/dec_exe_if.sv
rtl/reg_file.sv
rtl/inst_decoder.sv
execute/alu.sv
execute/exec_stage.sv
rtl/exu_top.sv
dv/exu_tb.sv
